/* design/cluster_pkg.sv */
`default_nettype none

package cluster_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Cluster shape
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_CORES     = 4;
    localparam int CORE_SEL_BITS = 2;

    // The output arbiter merges the core group with the auxiliary unit.
    localparam int OUT_NUM_SRCS   = 2;
    localparam int OUT_SEL_BITS   = 1;
    localparam int CORE_GROUP_IDX = 0;
    localparam int AUX_SRC_IDX    = 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

    // Each arbiter stage appends its source index below the incoming tag.
    localparam int CORE_TAG_WIDTH  = 8;
    localparam int GROUP_TAG_WIDTH = CORE_TAG_WIDTH + CORE_SEL_BITS;
    localparam int MEM_TAG_WIDTH   = GROUP_TAG_WIDTH + OUT_SEL_BITS;

    typedef logic [ADDR_WIDTH-1:0]      mem_addr_t;
    typedef logic [DATA_WIDTH-1:0]      mem_data_t;
    typedef logic [BYTEEN_WIDTH-1:0]    mem_byteen_t;
    typedef logic [CORE_TAG_WIDTH-1:0]  core_tag_t;
    typedef logic [GROUP_TAG_WIDTH-1:0] group_tag_t;
    typedef logic [MEM_TAG_WIDTH-1:0]   mem_tag_t;

endpackage

`default_nettype wire

/* design/mem_bus_if.sv */
`default_nettype none

interface mem_bus_if import cluster_pkg::*; #(
    parameter int TAG_WIDTH = CORE_TAG_WIDTH
) ();

    // Request channel.
    logic                 req_valid;
    logic                 req_rw;
    mem_addr_t            req_addr;
    mem_data_t            req_data;
    mem_byteen_t          req_byteen;
    logic [TAG_WIDTH-1:0] req_tag;
    logic                 req_ready;

    // Response channel. Only reads get a response, and responses come back in any order.
    logic                 rsp_valid;
    mem_data_t            rsp_data;
    logic [TAG_WIDTH-1:0] rsp_tag;
    logic                 rsp_ready;

    modport master (
        output req_valid, req_rw, req_addr, req_data, req_byteen, req_tag,
        input  req_ready,
        input  rsp_valid, rsp_data, rsp_tag,
        output rsp_ready
    );

    modport slave (
        input  req_valid, req_rw, req_addr, req_data, req_byteen, req_tag,
        output req_ready,
        output rsp_valid, rsp_data, rsp_tag,
        input  rsp_ready
    );

endinterface

`default_nettype wire

/* design/mem_skid_buffer.sv */
`default_nettype none

module mem_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,

    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    // The main register drives the output. The skid register catches the one
    // item that arrives in the cycle the output stalls. The skid register is
    // full exactly when in_ready is low, so in_ready comes straight from a flop.
    logic [WIDTH-1:0] skid_data;
    logic             main_free;

    assign main_free = !out_valid || out_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (main_free) begin
            // A full skid register has priority; otherwise take the input.
            out_valid <= in_valid || !in_ready;
            in_ready  <= 1'b1;
        end else if (in_valid && in_ready) begin
            in_ready <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Payload
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (main_free) begin
            out_data <= in_ready ? in_data : skid_data;
        end
        if (in_ready && !main_free) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* design/mem_arb.sv */
`default_nettype none

module mem_arb import cluster_pkg::*; #(
    parameter int NUM_REQS     = 4,
    parameter int TAG_IN_WIDTH = CORE_TAG_WIDTH,
    parameter int BUFFERED     = 0
) (
    input  logic      clk,
    input  logic      reset,

    mem_bus_if.slave  req_in_if [NUM_REQS],
    mem_bus_if.master req_out_if
);

    localparam int SEL_BITS      = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;
    localparam int TAG_OUT_WIDTH = TAG_IN_WIDTH + SEL_BITS;
    localparam int REQ_WIDTH     = 1 + ADDR_WIDTH + DATA_WIDTH + BYTEEN_WIDTH + TAG_OUT_WIDTH;
    localparam int RSP_WIDTH     = DATA_WIDTH + TAG_OUT_WIDTH;

    logic [NUM_REQS-1:0]                in_valid;
    logic [NUM_REQS-1:0][REQ_WIDTH-1:0] in_payload;
    logic [NUM_REQS-1:0]                in_rsp_ready;

    logic [SEL_BITS-1:0]      rr_ptr;
    logic [SEL_BITS-1:0]      rr_grant;
    logic [SEL_BITS-1:0]      lock_idx;
    logic [SEL_BITS-1:0]      sel_idx;
    logic                     arb_locked;

    logic                     arb_valid;
    logic                     arb_ready;
    logic [REQ_WIDTH-1:0]     arb_payload;

    logic                     out_valid;
    logic                     out_ready;
    logic [REQ_WIDTH-1:0]     out_payload;

    logic                     mem_rsp_valid;
    logic                     mem_rsp_ready;
    logic [RSP_WIDTH-1:0]     mem_rsp_payload;

    logic                     rsp_valid;
    logic                     rsp_ready;
    logic [RSP_WIDTH-1:0]     rsp_payload;
    mem_data_t                rsp_data;
    logic [TAG_OUT_WIDTH-1:0] rsp_tag;
    logic [SEL_BITS-1:0]      rsp_sel;

    // ~~~~~~~~~~~~~~~~~~~~
    // Source side
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_src
        assign in_valid[i]   = req_in_if[i].req_valid;
        // The source index goes into the low tag bits.
        assign in_payload[i] = {req_in_if[i].req_rw, req_in_if[i].req_addr,
                                req_in_if[i].req_data, req_in_if[i].req_byteen,
                                req_in_if[i].req_tag, SEL_BITS'(i)};
        assign req_in_if[i].req_ready = arb_valid && arb_ready && (sel_idx == SEL_BITS'(i));

        assign req_in_if[i].rsp_valid = rsp_valid && (rsp_sel == SEL_BITS'(i));
        assign req_in_if[i].rsp_data  = rsp_data;
        assign req_in_if[i].rsp_tag   = rsp_tag[TAG_OUT_WIDTH-1:SEL_BITS];
        assign in_rsp_ready[i]        = req_in_if[i].rsp_ready;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Round-robin select
    // ~~~~~~~~~~~~~~~~~~~~

    // First valid source at or after the pointer.
    always_comb begin
        int idx;
        logic found;
        rr_grant = '0;
        found    = 1'b0;
        for (int k = 0; k < NUM_REQS; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= NUM_REQS) begin
                idx = idx - NUM_REQS;
            end
            if (!found && in_valid[idx]) begin
                found    = 1'b1;
                rr_grant = SEL_BITS'(idx);
            end
        end
    end

    // A stalled grant stays locked so the output payload holds until it is taken.
    assign sel_idx     = arb_locked ? lock_idx : rr_grant;
    assign arb_valid   = in_valid[sel_idx];
    assign arb_payload = in_payload[sel_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr     <= '0;
            lock_idx   <= '0;
            arb_locked <= 1'b0;
        end else if (arb_valid && arb_ready) begin
            rr_ptr     <= (sel_idx == SEL_BITS'(NUM_REQS - 1)) ? '0 : sel_idx + 1'b1;
            arb_locked <= 1'b0;
        end else if (arb_valid) begin
            lock_idx   <= sel_idx;
            arb_locked <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory side
    // ~~~~~~~~~~~~~~~~~~~~

    assign req_out_if.req_valid = out_valid;
    assign {req_out_if.req_rw, req_out_if.req_addr, req_out_if.req_data,
            req_out_if.req_byteen, req_out_if.req_tag} = out_payload;
    assign out_ready = req_out_if.req_ready;

    assign mem_rsp_valid        = req_out_if.rsp_valid;
    assign mem_rsp_payload      = {req_out_if.rsp_data, req_out_if.rsp_tag};
    assign req_out_if.rsp_ready = mem_rsp_ready;

    if (BUFFERED != 0) begin : g_buffered
        mem_skid_buffer #(
            .WIDTH (REQ_WIDTH)
        ) req_buf (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (arb_valid),
            .in_data   (arb_payload),
            .in_ready  (arb_ready),
            .out_valid (out_valid),
            .out_data  (out_payload),
            .out_ready (out_ready)
        );

        mem_skid_buffer #(
            .WIDTH (RSP_WIDTH)
        ) rsp_buf (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (mem_rsp_valid),
            .in_data   (mem_rsp_payload),
            .in_ready  (mem_rsp_ready),
            .out_valid (rsp_valid),
            .out_data  (rsp_payload),
            .out_ready (rsp_ready)
        );
    end else begin : g_direct
        assign out_valid     = arb_valid;
        assign out_payload   = arb_payload;
        assign arb_ready     = out_ready;
        assign rsp_valid     = mem_rsp_valid;
        assign rsp_payload   = mem_rsp_payload;
        assign mem_rsp_ready = rsp_ready;
    end

    // Responses are steered by the low tag bits.
    assign {rsp_data, rsp_tag} = rsp_payload;
    assign rsp_sel             = rsp_tag[SEL_BITS-1:0];
    assign rsp_ready           = in_rsp_ready[rsp_sel];

endmodule

`default_nettype wire

/* design/gpu_cluster.sv */
`default_nettype none

module gpu_cluster import cluster_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,

    // Core memory ports
    input  logic [NUM_CORES-1:0]             core_req_valid,
    input  logic [NUM_CORES-1:0]             core_req_rw,
    input  mem_addr_t [NUM_CORES-1:0]        core_req_addr,
    input  mem_data_t [NUM_CORES-1:0]        core_req_data,
    input  mem_byteen_t [NUM_CORES-1:0]      core_req_byteen,
    input  core_tag_t [NUM_CORES-1:0]        core_req_tag,
    output logic [NUM_CORES-1:0]             core_req_ready,

    output logic [NUM_CORES-1:0]             core_rsp_valid,
    output mem_data_t [NUM_CORES-1:0]        core_rsp_data,
    output core_tag_t [NUM_CORES-1:0]        core_rsp_tag,
    input  logic [NUM_CORES-1:0]             core_rsp_ready,

    // Auxiliary unit port
    input  logic                             aux_req_valid,
    input  logic                             aux_req_rw,
    input  mem_addr_t                        aux_req_addr,
    input  mem_data_t                        aux_req_data,
    input  mem_byteen_t                      aux_req_byteen,
    input  core_tag_t                        aux_req_tag,
    output logic                             aux_req_ready,

    output logic                             aux_rsp_valid,
    output mem_data_t                        aux_rsp_data,
    output core_tag_t                        aux_rsp_tag,
    input  logic                             aux_rsp_ready,

    // Cluster memory port
    output logic                             mem_req_valid,
    output logic                             mem_req_rw,
    output mem_addr_t                        mem_req_addr,
    output mem_data_t                        mem_req_data,
    output mem_byteen_t                      mem_req_byteen,
    output mem_tag_t                         mem_req_tag,
    input  logic                             mem_req_ready,

    input  logic                             mem_rsp_valid,
    input  mem_data_t                        mem_rsp_data,
    input  mem_tag_t                         mem_rsp_tag,
    output logic                             mem_rsp_ready,

    // Status
    input  logic [NUM_CORES-1:0]             core_busy,
    output logic                             busy
);

    mem_bus_if #(.TAG_WIDTH(CORE_TAG_WIDTH))  core_bus_if  [NUM_CORES] ();
    mem_bus_if #(.TAG_WIDTH(GROUP_TAG_WIDTH)) group_bus_if [OUT_NUM_SRCS] ();
    mem_bus_if #(.TAG_WIDTH(MEM_TAG_WIDTH))   cluster_mem_if ();

    // ~~~~~~~~~~~~~~~~~~~~
    // Core ports
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        assign core_bus_if[i].req_valid  = core_req_valid[i];
        assign core_bus_if[i].req_rw     = core_req_rw[i];
        assign core_bus_if[i].req_addr   = core_req_addr[i];
        assign core_bus_if[i].req_data   = core_req_data[i];
        assign core_bus_if[i].req_byteen = core_req_byteen[i];
        assign core_bus_if[i].req_tag    = core_req_tag[i];
        assign core_req_ready[i]         = core_bus_if[i].req_ready;

        assign core_rsp_valid[i]         = core_bus_if[i].rsp_valid;
        assign core_rsp_data[i]          = core_bus_if[i].rsp_data;
        assign core_rsp_tag[i]           = core_bus_if[i].rsp_tag;
        assign core_bus_if[i].rsp_ready  = core_rsp_ready[i];
    end

    // Registered on both paths, so the core group meets timing on its own.
    mem_arb #(
        .NUM_REQS     (NUM_CORES),
        .TAG_IN_WIDTH (CORE_TAG_WIDTH),
        .BUFFERED     (1)
    ) core_arb (
        .clk        (clk),
        .reset      (reset),
        .req_in_if  (core_bus_if),
        .req_out_if (group_bus_if[CORE_GROUP_IDX])
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Auxiliary port
    // ~~~~~~~~~~~~~~~~~~~~

    // The narrower auxiliary tag is zero-extended to the group width.
    assign group_bus_if[AUX_SRC_IDX].req_valid  = aux_req_valid;
    assign group_bus_if[AUX_SRC_IDX].req_rw     = aux_req_rw;
    assign group_bus_if[AUX_SRC_IDX].req_addr   = aux_req_addr;
    assign group_bus_if[AUX_SRC_IDX].req_data   = aux_req_data;
    assign group_bus_if[AUX_SRC_IDX].req_byteen = aux_req_byteen;
    assign group_bus_if[AUX_SRC_IDX].req_tag    = group_tag_t'(aux_req_tag);
    assign aux_req_ready                        = group_bus_if[AUX_SRC_IDX].req_ready;

    assign aux_rsp_valid                        = group_bus_if[AUX_SRC_IDX].rsp_valid;
    assign aux_rsp_data                         = group_bus_if[AUX_SRC_IDX].rsp_data;
    assign aux_rsp_tag  = group_bus_if[AUX_SRC_IDX].rsp_tag[CORE_TAG_WIDTH-1:0];
    assign group_bus_if[AUX_SRC_IDX].rsp_ready  = aux_rsp_ready;

    mem_arb #(
        .NUM_REQS     (OUT_NUM_SRCS),
        .TAG_IN_WIDTH (GROUP_TAG_WIDTH),
        .BUFFERED     (0)
    ) out_arb (
        .clk        (clk),
        .reset      (reset),
        .req_in_if  (group_bus_if),
        .req_out_if (cluster_mem_if)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory port
    // ~~~~~~~~~~~~~~~~~~~~

    assign mem_req_valid            = cluster_mem_if.req_valid;
    assign mem_req_rw               = cluster_mem_if.req_rw;
    assign mem_req_addr             = cluster_mem_if.req_addr;
    assign mem_req_data             = cluster_mem_if.req_data;
    assign mem_req_byteen           = cluster_mem_if.req_byteen;
    assign mem_req_tag              = cluster_mem_if.req_tag;
    assign cluster_mem_if.req_ready = mem_req_ready;

    assign cluster_mem_if.rsp_valid = mem_rsp_valid;
    assign cluster_mem_if.rsp_data  = mem_rsp_data;
    assign cluster_mem_if.rsp_tag   = mem_rsp_tag;
    assign mem_rsp_ready            = cluster_mem_if.rsp_ready;

    // The cluster is busy while any core is.
    assign busy = |core_busy;

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released just after an edge, so the DUT sees it synchronously.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/gpu_cluster_properties.sv */
`default_nettype none

module gpu_cluster_properties import cluster_pkg::*; (
    input logic                      clk,
    input logic                      reset,
    input logic [NUM_CORES-1:0]      core_rsp_valid,
    input logic [NUM_CORES-1:0]      core_rsp_ready,
    input core_tag_t [NUM_CORES-1:0] core_rsp_tag,
    input logic                      aux_req_valid,
    input core_tag_t                 aux_req_tag,
    input logic                      aux_rsp_valid,
    input logic                      aux_rsp_ready,
    input core_tag_t                 aux_rsp_tag,
    input logic                      mem_req_valid,
    input logic                      mem_req_rw,
    input mem_addr_t                 mem_req_addr,
    input mem_data_t                 mem_req_data,
    input mem_byteen_t               mem_req_byteen,
    input mem_tag_t                  mem_req_tag,
    input logic                      mem_req_ready,
    input logic [NUM_CORES-1:0]      core_busy,
    input logic                      busy
);

    int error_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory request port
    // ~~~~~~~~~~~~~~~~~~~~

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_tag)
            && $stable(mem_req_addr) && $stable(mem_req_data) && $stable(mem_req_rw)
            && $stable(mem_req_byteen))
        else begin
            error_count++;
            $error("mem_req payload changed while stalled");
        end

    // Core tags carry the core index in their top two bits.
    a_core_origin: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_tag[0] |-> mem_req_tag[2:1] == mem_req_tag[10:9])
        else begin
            error_count++;
            $error("core index in mem_req_tag is wrong");
        end

    a_aux_origin: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && mem_req_tag[0] |-> aux_req_valid
            && mem_req_tag[10:1] == {2'b00, aux_req_tag})
        else begin
            error_count++;
            $error("auxiliary mem_req_tag is wrong");
        end

    // ~~~~~~~~~~~~~~~~~~~~
    // Responses and status
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            core_rsp_valid[i] && !core_rsp_ready[i] |=> core_rsp_valid[i]
                && $stable(core_rsp_tag[i]))
            else begin
                error_count++;
                $error("core response dropped before accept");
            end
    end

    a_aux_hold: assert property (@(posedge clk) disable iff (reset)
        aux_rsp_valid && !aux_rsp_ready |=> aux_rsp_valid && $stable(aux_rsp_tag))
        else begin
            error_count++;
            $error("aux response dropped before accept");
        end

    a_busy: assert property (@(posedge clk) busy == |core_busy)
        else begin
            error_count++;
            $error("busy differs from OR of core_busy");
        end

    a_reset_idle: assert property (@(posedge clk)
        reset && $past(reset) |-> !mem_req_valid && core_rsp_valid == '0 && !aux_rsp_valid)
        else begin
            error_count++;
            $error("valid output high during reset");
        end

endmodule

`default_nettype wire

/* testbench/gpu_cluster_tb.sv */
`default_nettype none

module gpu_cluster_tb import cluster_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_SRCS   = NUM_CORES + 1;
    localparam int AUX        = NUM_CORES;
    localparam int TOTAL_REQS = 208;

    logic clk, reset;
    logic [NUM_CORES-1:0] core_req_valid, core_req_rw, core_req_ready;
    logic [NUM_CORES-1:0] core_rsp_valid, core_rsp_ready, core_busy;
    mem_addr_t [NUM_CORES-1:0] core_req_addr;
    mem_data_t [NUM_CORES-1:0] core_req_data, core_rsp_data;
    mem_byteen_t [NUM_CORES-1:0] core_req_byteen;
    core_tag_t [NUM_CORES-1:0] core_req_tag, core_rsp_tag;
    logic aux_req_valid, aux_req_rw, aux_req_ready, aux_rsp_valid, aux_rsp_ready;
    mem_addr_t aux_req_addr, mem_req_addr;
    mem_data_t aux_req_data, aux_rsp_data, mem_req_data, mem_rsp_data;
    mem_byteen_t aux_req_byteen, mem_req_byteen;
    core_tag_t aux_req_tag, aux_rsp_tag;
    logic mem_req_valid, mem_req_rw, mem_req_ready, mem_rsp_valid, mem_rsp_ready, busy;
    mem_tag_t mem_req_tag, mem_rsp_tag;

    core_tag_t tag_q[NUM_SRCS][$];
    mem_addr_t addr_q[NUM_SRCS][$];
    int        tag_cnt[NUM_SRCS];
    mem_data_t expect_word[mem_addr_t];
    mem_data_t mem_store[mem_addr_t];
    mem_tag_t  pend_tag[$];
    mem_data_t pend_data[$];
    int        pend_due[$];
    int        issued, seen, cycle;
    logic      bp_on, fair_on, rsp_taken;
    logic [NUM_CORES-1:0] fair_seen;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clock_gen (.clk(clk), .reset(reset));

    gpu_cluster u_gpu_cluster (.*);

    bind gpu_cluster gpu_cluster_properties props (.*);

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic mem_data_t merge_bytes(mem_data_t old, mem_data_t data, mem_byteen_t be);
        for (int b = 0; b < BYTEEN_WIDTH; b++) begin
            if (be[b]) old[b*8 +: 8] = data[b*8 +: 8];
        end
        return old;
    endfunction

    // Unwritten words read as the address plus a fixed pattern.
    function automatic mem_data_t initial_word(mem_addr_t addr);
        return addr + 32'h5A5A0000;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Source drivers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic send(input int src, input logic rw, input mem_addr_t addr,
                        input mem_data_t data, input mem_byteen_t be);
        core_tag_t tag;
        tag = (src == AUX) ? core_tag_t'(tag_cnt[src]) : {2'(src), 6'(tag_cnt[src])};
        tag_cnt[src]++;
        if (src == AUX) begin
            {aux_req_valid, aux_req_rw, aux_req_addr} = {1'b1, rw, addr};
            {aux_req_data, aux_req_byteen, aux_req_tag} = {data, be, tag};
        end else begin
            {core_req_valid[src], core_req_rw[src], core_req_addr[src]} = {1'b1, rw, addr};
            core_req_data[src]   = data;
            core_req_byteen[src] = be;
            core_req_tag[src]    = tag;
        end
        @(negedge clk);
        while (!((src == AUX) ? aux_req_ready : core_req_ready[src])) @(negedge clk);
        issued++;
        if (rw) begin
            if (!expect_word.exists(addr)) expect_word[addr] = initial_word(addr);
            expect_word[addr] = merge_bytes(expect_word[addr], data, be);
        end else begin
            tag_q[src].push_back(tag);
            addr_q[src].push_back(addr);
        end
        @(posedge clk);
        #1;
        if (src == AUX) aux_req_valid = 1'b0;
        else core_req_valid[src] = 1'b0;
    endtask

    task automatic write_words(input int src, input mem_addr_t base, input mem_byteen_t be);
        for (int k = 0; k < 4; k++) send(src, 1'b1, base + k, $urandom, be);
    endtask

    task automatic read_words(input int src, input mem_addr_t base, input int n);
        for (int k = 0; k < n; k++) begin
            send(src, 1'b0, base + k, '0, '0);
        end
    endtask

    // Reads of shared words mixed with writes to a private scratch area.
    task automatic mixed_words(input int src, input mem_addr_t base, input mem_addr_t scratch,
                               input int n);
        for (int k = 0; k < n; k++) begin
            if ($urandom_range(3) == 0) begin
                send(src, 1'b1, scratch + k, $urandom, mem_byteen_t'($urandom));
            end else begin
                send(src, 1'b0, base + $urandom_range(15), $urandom, mem_byteen_t'($urandom));
            end
        end
    endtask

    task automatic drain();
        int waiting;
        do begin
            @(posedge clk);
            waiting = pend_tag.size() + int'(mem_rsp_valid) + issued - seen;
            for (int s = 0; s < NUM_SRCS; s++) waiting += tag_q[s].size();
        end while (waiting != 0);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Scoreboard and memory model
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_rsp(input int src, input core_tag_t tag, input mem_data_t data);
        int pos;
        mem_data_t exp;
        pos = -1;
        for (int k = 0; k < tag_q[src].size(); k++) if (tag_q[src][k] == tag) pos = k;
        assert (pos >= 0) else abort_run("response carries a tag no read is waiting for");
        exp = expect_word.exists(addr_q[src][pos]) ? expect_word[addr_q[src][pos]]
                                                   : initial_word(addr_q[src][pos]);
        assert (data == exp)
            else report_mismatch((src == AUX) ? "aux_rsp_data" : "core_rsp_data", data, exp);
        tag_q[src].delete(pos);
        addr_q[src].delete(pos);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (core_rsp_valid[i] && core_rsp_ready[i])
                    check_rsp(i, core_rsp_tag[i], core_rsp_data[i]);
            end
            if (aux_rsp_valid && aux_rsp_ready) check_rsp(AUX, aux_rsp_tag, aux_rsp_data);
            if (mem_rsp_valid && mem_rsp_ready) rsp_taken = 1'b1;
            if (mem_req_valid && mem_req_ready) begin
                seen++;
                if (!mem_store.exists(mem_req_addr)) begin
                    mem_store[mem_req_addr] = initial_word(mem_req_addr);
                end
                if (mem_req_rw) begin
                    mem_store[mem_req_addr] = merge_bytes(mem_store[mem_req_addr], mem_req_data,
                                                          mem_req_byteen);
                end else begin
                    pend_tag.push_back(mem_req_tag);
                    pend_data.push_back(mem_store[mem_req_addr]);
                    pend_due.push_back(cycle + $urandom_range(5));
                end
                if (fair_on && !mem_req_tag[0]) begin
                    assert (!fair_seen[mem_req_tag[2:1]])
                        else abort_run("a core was granted twice in one round-robin round");
                    fair_seen[mem_req_tag[2:1]] = 1'b1;
                    if (&fair_seen) fair_seen = '0;
                end
            end
        end
    end

    // Memory side and ready inputs change just after each rising edge.
    always @(posedge clk) begin
        int pick;
        #1;
        cycle++;
        core_busy      = NUM_CORES'($urandom);
        mem_req_ready  = bp_on ? $urandom_range(1) : 1'b1;
        core_rsp_ready = bp_on ? NUM_CORES'($urandom) : '1;
        aux_rsp_ready  = bp_on ? $urandom_range(1) : 1'b1;
        if (rsp_taken) begin
            mem_rsp_valid = 1'b0;
            rsp_taken     = 1'b0;
        end
        if (!mem_rsp_valid && pend_tag.size() != 0) begin
            pick = $urandom_range(pend_tag.size() - 1);
            if (pend_due[pick] <= cycle) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_tag   = pend_tag[pick];
                mem_rsp_data  = pend_data[pick];
                pend_tag.delete(pick);
                pend_data.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

    always @(u_gpu_cluster.props.error_count) begin
        if (u_gpu_cluster.props.error_count != 0) abort_run("a port property failed");
    end

    initial begin
        #(TOTAL_REQS * 200 * CLK_PERIOD);
        abort_run("watchdog expired before all requests completed");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Test phases
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(12684));
        {core_req_valid, core_req_rw, core_req_addr, core_req_data} = '0;
        {core_req_byteen, core_req_tag, core_rsp_ready, core_busy} = '0;
        {aux_req_valid, aux_req_rw, aux_req_addr, aux_req_data} = '0;
        {aux_req_byteen, aux_req_tag, aux_rsp_ready} = '0;
        {mem_req_ready, mem_rsp_valid, mem_rsp_data, mem_rsp_tag} = '0;
        {issued, seen, cycle, bp_on, fair_on, rsp_taken, fair_seen} = '0;
        for (int s = 0; s < NUM_SRCS; s++) tag_cnt[s] = 0;
        @(negedge reset);
        @(posedge clk);
        #1;
        // Each core writes its own byte lane of shared words.
        fork
            write_words(0, 32'h100, 4'b0001);
            write_words(1, 32'h100, 4'b0010);
            write_words(2, 32'h100, 4'b0100);
            write_words(3, 32'h100, 4'b1000);
            write_words(AUX, 32'h200, 4'b1111);
        join
        drain();
        fork
            read_words(0, 32'h100, 4);
            read_words(1, 32'h100, 4);
            read_words(2, 32'h100, 4);
            read_words(3, 32'h100, 4);
            begin
                read_words(AUX, 32'h200, 4);
                read_words(AUX, 32'h100, 4);
            end
        join
        drain();
        bp_on = 1'b1;
        fork
            mixed_words(0, 32'h100, 32'h400, 20);
            mixed_words(1, 32'h100, 32'h420, 20);
            mixed_words(2, 32'h100, 32'h440, 20);
            mixed_words(3, 32'h100, 32'h460, 20);
            mixed_words(AUX, 32'h100, 32'h480, 20);
        join
        drain();
        bp_on   = 1'b0;
        fair_on = 1'b1;
        fork
            read_words(0, 32'h300, 16);
            read_words(1, 32'h310, 16);
            read_words(2, 32'h320, 16);
            read_words(3, 32'h330, 16);
        join
        drain();
        fair_on = 1'b0;
        if (u_gpu_cluster.props.error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* gpu_cluster.f */
design/cluster_pkg.sv
design/mem_bus_if.sv
design/mem_skid_buffer.sv
design/mem_arb.sv
design/gpu_cluster.sv
testbench/clock_gen.sv
testbench/gpu_cluster_properties.sv
testbench/gpu_cluster_tb.sv

/* Bender.yml */
package:
  name: gpu_cluster

sources:
  - files:
      - design/cluster_pkg.sv
      - design/mem_bus_if.sv
      - design/mem_skid_buffer.sv
      - design/mem_arb.sv
      - design/gpu_cluster.sv
  - target: simulation
    files:
      - testbench/clock_gen.sv
      - testbench/gpu_cluster_properties.sv
      - testbench/gpu_cluster_tb.sv
